/* tb_sram_model.sv */
`default_nettype none

`include "tluh_sram_macros.svh"

module tb_sram_model (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Grant pattern and error injection from the testbench
  input  logic                     grant_en_i,
  input  logic                     inject_err_i,
  // SRAM request side
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [`TLUH_SRAM_AW-1:0] addr_i,
  input  logic [`TLUH_DW-1:0]      wdata_i,
  input  logic [`TLUH_DW-1:0]      wmask_i,
  output logic                     gnt_o,
  // Read return, one cycle after the grant
  output logic                     rvalid_o,
  output logic [`TLUH_DW-1:0]      rdata_o,
  output logic                     rerror_o
);

  logic [`TLUH_DW-1:0] mem [2**`TLUH_SRAM_AW];

  // Pattern built from the full word address
  initial begin
    for (int i = 0; i < 2**`TLUH_SRAM_AW; i++) begin
      mem[i] = {6'h2a, i[9:0], 6'h15, i[9:0]};
    end
  end

  // Grant follows the random enable, whether or not req_i is high
  assign gnt_o = grant_en_i;

  // Bit-masked write
  always @(posedge clk_i) begin
    if (req_i && gnt_o && we_i) begin
      mem[addr_i] <= (mem[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
    end
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      rerror_o <= 1'b0;
    end else begin
      rvalid_o <= req_i && gnt_o && !we_i;
      if (req_i && gnt_o && !we_i) begin
        rdata_o  <= mem[addr_i];
        // Error flag sampled with the read grant
        rerror_o <= inject_err_i;
      end
    end
  end

endmodule

`default_nettype wire

/* tb_tluh_sram_adapter.sv */
`default_nettype none

`include "tluh_sram_macros.svh"

module tb_tluh_sram_adapter;

  localparam int Timeout = 200;

  typedef struct packed {
    logic [2:0]  opcode;
    logic [2:0]  param;
    logic [1:0]  size;
    logic [31:0] addr;
    logic [3:0]  mask;
    logic [31:0] data;
    logic        inject;
    logic        exp_err;
  } entry_t;

  typedef struct packed {
    logic [2:0]  opcode;
    logic [1:0]  size;
    logic [7:0]  source;
    logic [31:0] data;
    logic        err;
  } rsp_t;

  logic clk;
  logic rst_n;
  logic a_valid;
  logic [2:0] a_opcode;
  logic [2:0] a_param;
  logic [1:0] a_size;
  logic [7:0] a_source;
  logic [31:0] a_address;
  logic [3:0] a_mask;
  logic [31:0] a_data;
  logic a_ready;
  logic d_valid;
  logic [2:0] d_opcode;
  logic [1:0] d_size;
  logic [7:0] d_source;
  logic [31:0] d_data;
  logic d_error;
  logic d_ready;
  logic req;
  logic we;
  logic [9:0] addr;
  logic [31:0] wdata;
  logic [31:0] wmask;
  logic gnt;
  logic rvalid;
  logic [31:0] rdata;
  logic rerror;
  logic grant_en;
  logic inject_err;

  integer seed;
  integer rnd;
  int mismatches;
  int timeouts;
  bit abort;
  entry_t tests[$];
  string names[$];
  rsp_t exp_q[$];
  string exp_name_q[$];
  logic [31:0] ref_mem [1024];

  tluh_sram_adapter u_tluh_sram_adapter (
    .clk_i (clk), .rst_ni (rst_n),
    .a_valid_i (a_valid), .a_opcode_i (a_opcode), .a_param_i (a_param),
    .a_size_i (a_size), .a_source_i (a_source), .a_address_i (a_address),
    .a_mask_i (a_mask), .a_data_i (a_data), .a_ready_o (a_ready),
    .d_valid_o (d_valid), .d_opcode_o (d_opcode), .d_size_o (d_size),
    .d_source_o (d_source), .d_data_o (d_data), .d_error_o (d_error),
    .d_ready_i (d_ready),
    .req_o (req), .we_o (we), .addr_o (addr), .wdata_o (wdata), .wmask_o (wmask),
    .gnt_i (gnt), .rvalid_i (rvalid), .rdata_i (rdata), .rerror_i (rerror)
  );

  tb_sram_model u_sram_model (
    .clk_i (clk), .rst_ni (rst_n), .grant_en_i (grant_en), .inject_err_i (inject_err),
    .req_i (req), .we_i (we), .addr_i (addr), .wdata_i (wdata), .wmask_i (wmask),
    .gnt_o (gnt), .rvalid_o (rvalid), .rdata_o (rdata), .rerror_o (rerror)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Same pattern the SRAM model starts from
  function automatic logic [31:0] fill_word(input logic [9:0] a);
    return {6'h2a, a, 6'h15, a};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] upd,
                                              input logic [3:0] mask);
    logic [31:0] res;
    for (int b = 0; b < 4; b++) begin
      res[8*b +: 8] = mask[b] ? upd[8*b +: 8] : old[8*b +: 8];
    end
    return res;
  endfunction

  // TileLink atomic semantics on a whole word
  function automatic logic [31:0] atomic_calc(input logic arith, input logic [2:0] fn,
                                              input logic [31:0] old, input logic [31:0] opnd);
    if (arith) begin
      case (fn)
        3'd0: return ($signed(opnd) < $signed(old)) ? opnd : old;
        3'd1: return ($signed(opnd) > $signed(old)) ? opnd : old;
        3'd2: return (opnd < old) ? opnd : old;
        3'd3: return (opnd > old) ? opnd : old;
        default: return old + opnd;
      endcase
    end
    case (fn)
      3'd0: return old ^ opnd;
      3'd1: return old | opnd;
      3'd2: return old & opnd;
      default: return opnd;
    endcase
  endfunction

  task automatic add_test(input string name, input logic [2:0] op, input logic [2:0] param,
                          input logic [1:0] size, input logic [31:0] a, input logic [3:0] mask,
                          input logic [31:0] data, input logic inject, input logic exp_err);
    tests.push_back({op, param, size, a, mask, data, inject, exp_err});
    names.push_back(name);
  endtask

  // Expected response of an accepted beat, reference memory updated in A order
  task automatic expect_response(input int i);
    entry_t e;
    rsp_t x;
    logic [31:0] old;
    logic [9:0] w;
    e = tests[i];
    w = e.addr[`TLUH_SRAM_AW+1:2];
    old = ref_mem[w];
    x.opcode = (e.opcode inside {`TLUH_GET, `TLUH_ARITH, `TLUH_LOGIC}) ?
               `TLUH_ACCESS_ACK_DATA : `TLUH_ACCESS_ACK;
    x.size = e.size;
    x.source = 8'h20 + 8'(i);
    x.err = e.exp_err;
    x.data = '0;
    // Illegal requests never touch memory
    if (!e.exp_err || e.inject) begin
      case (e.opcode)
        `TLUH_PUT_FULL, `TLUH_PUT_PARTIAL: ref_mem[w] = merge_bytes(old, e.data, e.mask);
        `TLUH_ARITH, `TLUH_LOGIC: begin
          x.data = old;
          ref_mem[w] = merge_bytes(old, atomic_calc(e.opcode == `TLUH_ARITH, e.param, old,
                                                    e.data), e.mask);
        end
        default: x.data = old;
      endcase
    end
    exp_q.push_back(x);
    exp_name_q.push_back(names[i]);
  endtask

  task automatic check_value(input string test, input string field, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      mismatches++;
      $display("Mismatch %s %s: expected %h, actual %h", test, field, exp, act);
    end
  endtask

  task automatic send_requests();
    int cycles;
    @(posedge clk);
    #5;
    for (int i = 0; i < tests.size() && !abort; i++) begin
      a_valid = 1'b1;
      a_opcode = tests[i].opcode;
      a_param = tests[i].param;
      a_size = tests[i].size;
      a_source = 8'h20 + 8'(i);
      a_address = tests[i].addr;
      a_mask = tests[i].mask;
      a_data = tests[i].data;
      inject_err = tests[i].inject;
      cycles = 0;
      do begin
        @(negedge clk);
        cycles++;
      end while (!a_ready && cycles < Timeout);
      if (!a_ready) begin
        timeouts++;
        abort = 1'b1;
        $display("Request %s was never accepted", names[i]);
      end else begin
        expect_response(i);
      end
      @(posedge clk);
      #5;
    end
    a_valid = 1'b0;
    inject_err = 1'b0;
  endtask

  task automatic collect_responses();
    int cycles;
    rsp_t x;
    string test;
    for (int k = 0; k < tests.size() && !abort; k++) begin
      cycles = 0;
      do begin
        @(negedge clk);
        cycles++;
      end while (!(d_valid && d_ready) && cycles < Timeout);
      if (!(d_valid && d_ready)) begin
        timeouts++;
        abort = 1'b1;
        $display("No response arrived for request %0d", k);
      end else if (exp_q.size() == 0) begin
        mismatches++;
        $display("A response arrived with no request outstanding");
      end else begin
        x = exp_q.pop_front();
        test = exp_name_q.pop_front();
        check_value(test, "opcode", 32'(x.opcode), 32'(d_opcode));
        check_value(test, "size", 32'(x.size), 32'(d_size));
        check_value(test, "source", 32'(x.source), 32'(d_source));
        check_value(test, "error", 32'(x.err), 32'(d_error));
        check_value(test, "data", x.data, d_data);
      end
    end
  endtask

  initial begin
    seed = 32'h62bb_27ce;
    rst_n = 1'b0;
    a_valid = 1'b0;
    a_opcode = '0;
    a_param = '0;
    a_size = '0;
    a_source = '0;
    a_address = '0;
    a_mask = '0;
    a_data = '0;
    d_ready = 1'b0;
    grant_en = 1'b0;
    inject_err = 1'b0;
    mismatches = 0;
    timeouts = 0;
    abort = 1'b0;
    for (int i = 0; i < 1024; i++) begin
      ref_mem[i] = fill_word(10'(i));
    end
    //       name              opcode            prm   sz    address  mask     data         inj err
    add_test("put_full",       `TLUH_PUT_FULL,    3'd0, 2'd2, 32'h100, 4'b1111, 32'h1234_5678, 0, 0);
    add_test("get_full",       `TLUH_GET,         3'd0, 2'd2, 32'h100, 4'b1111, 32'h0,         0, 0);
    add_test("put_partial",    `TLUH_PUT_PARTIAL, 3'd0, 2'd2, 32'h100, 4'b0101, 32'haabb_ccdd, 0, 0);
    add_test("get_merged",     `TLUH_GET,         3'd0, 2'd2, 32'h100, 4'b1111, 32'h0,         0, 0);
    add_test("put_amo_base",   `TLUH_PUT_FULL,    3'd0, 2'd2, 32'h104, 4'b1111, 32'h8000_0010, 0, 0);
    add_test("amo_min",        `TLUH_ARITH,       3'd0, 2'd2, 32'h104, 4'b1111, 32'h0000_0005, 0, 0);
    add_test("amo_max",        `TLUH_ARITH,       3'd1, 2'd2, 32'h104, 4'b1111, 32'h0000_0005, 0, 0);
    add_test("amo_minu",       `TLUH_ARITH,       3'd2, 2'd2, 32'h104, 4'b1111, 32'h0000_0003, 0, 0);
    add_test("amo_maxu",       `TLUH_ARITH,       3'd3, 2'd2, 32'h104, 4'b1111, 32'hffff_0000, 0, 0);
    add_test("amo_add",        `TLUH_ARITH,       3'd4, 2'd2, 32'h104, 4'b1111, 32'h0001_0001, 0, 0);
    add_test("amo_add_half",   `TLUH_ARITH,       3'd4, 2'd1, 32'h106, 4'b1100, 32'h0003_0000, 0, 0);
    add_test("amo_xor",        `TLUH_LOGIC,       3'd0, 2'd2, 32'h104, 4'b1111, 32'hf0f0_f0f0, 0, 0);
    add_test("amo_or",         `TLUH_LOGIC,       3'd1, 2'd2, 32'h104, 4'b1111, 32'h0000_ff00, 0, 0);
    add_test("amo_and",        `TLUH_LOGIC,       3'd2, 2'd2, 32'h104, 4'b1111, 32'h0ff0_0ff0, 0, 0);
    add_test("amo_swap",       `TLUH_LOGIC,       3'd3, 2'd2, 32'h104, 4'b1111, 32'hcafe_f00d, 0, 0);
    add_test("get_after_amo",  `TLUH_GET,         3'd0, 2'd2, 32'h104, 4'b1111, 32'h0,         0, 0);
    add_test("intent_err",     `TLUH_INTENT,      3'd0, 2'd2, 32'h104, 4'b1111, 32'h0,         0, 1);
    add_test("size_err",       `TLUH_GET,         3'd0, 2'd3, 32'h100, 4'b1111, 32'h0,         0, 1);
    add_test("misalign_err",   `TLUH_GET,         3'd0, 2'd2, 32'h102, 4'b1111, 32'h0,         0, 1);
    add_test("arith_fn_err",   `TLUH_ARITH,       3'd5, 2'd2, 32'h104, 4'b1111, 32'h1,         0, 1);
    add_test("logic_fn_err",   `TLUH_LOGIC,       3'd4, 2'd2, 32'h104, 4'b1111, 32'h1,         0, 1);
    add_test("get_unchanged",  `TLUH_GET,         3'd0, 2'd2, 32'h104, 4'b1111, 32'h0,         0, 0);
    add_test("get_byte",       `TLUH_GET,         3'd0, 2'd0, 32'h105, 4'b0010, 32'h0,         0, 0);
    add_test("get_fill",       `TLUH_GET,         3'd0, 2'd2, 32'h3fc, 4'b1111, 32'h0,         0, 0);
    add_test("get_rerror",     `TLUH_GET,         3'd0, 2'd2, 32'h200, 4'b1111, 32'h0,         1, 1);
    add_test("get_after_rerr", `TLUH_GET,         3'd0, 2'd2, 32'h200, 4'b1111, 32'h0,         0, 0);
    repeat (16) @(posedge clk);
    #5;
    rst_n = 1'b1;
    // Requests go out back to back while responses drain in order
    fork
      send_requests();
      collect_responses();
    join
    $display("Finished with %0d mismatches and %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0 && exp_q.size() == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Random SRAM grant and host back-pressure, a little after each edge
  initial begin
    forever begin
      @(posedge clk);
      #3;
      if (rst_n) begin
        rnd = $random(seed);
        grant_en = (rnd[1:0] != 2'b00);
        d_ready = (rnd[3:2] != 2'b00);
      end
    end
  end

endmodule

`default_nettype wire

/* tluh_atomic_alu.sv */
`default_nettype none

`include "tluh_sram_macros.svh"

module tluh_atomic_alu import tluh_sram_pkg::*; (
  input  logic                 is_arith_i,
  input  atomic_param_u        func_i,
  input  logic [`TLUH_DW-1:0]  old_i,
  input  logic [`TLUH_DW-1:0]  operand_i,
  input  logic [`TLUH_DBW-1:0] mask_i,
  output logic [`TLUH_DW-1:0]  result_o
);

  logic                lt_s;
  logic                lt_u;
  logic [`TLUH_DW-1:0] calc;

  // Operand below memory value, signed and unsigned
  assign lt_s = $signed(operand_i) < $signed(old_i);
  assign lt_u = operand_i < old_i;

  always_comb begin
    calc = old_i;
    if (is_arith_i) begin
      case (func_i.arith_fn)
        `TLUH_ARITH_MIN:  calc = lt_s ? operand_i : old_i;
        `TLUH_ARITH_MAX:  calc = lt_s ? old_i : operand_i;
        `TLUH_ARITH_MINU: calc = lt_u ? operand_i : old_i;
        `TLUH_ARITH_MAXU: calc = lt_u ? old_i : operand_i;
        `TLUH_ARITH_ADD:  calc = old_i + operand_i;
        // Illegal codes are filtered before the SRAM
        default:          calc = old_i;
      endcase
    end else begin
      case (func_i.logic_fn)
        `TLUH_LOGIC_XOR:  calc = old_i ^ operand_i;
        `TLUH_LOGIC_OR:   calc = old_i | operand_i;
        `TLUH_LOGIC_AND:  calc = old_i & operand_i;
        `TLUH_LOGIC_SWAP: calc = operand_i;
        default:          calc = old_i;
      endcase
    end
  end

  // Unselected lanes keep the memory value
  always_comb begin
    for (int i = 0; i < `TLUH_DBW; i++) begin
      result_o[8*i +: 8] = mask_i[i] ? calc[8*i +: 8] : old_i[8*i +: 8];
    end
  end

endmodule

`default_nettype wire

/* tluh_fifo_sync.sv */
`default_nettype none

module tluh_fifo_sync #(
  parameter int Width = 8,
  parameter int Depth = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  // Write side
  input  logic             wvalid_i,
  output logic             wready_o,
  input  logic [Width-1:0] wdata_i,
  // Read side
  output logic             rvalid_o,
  input  logic             rready_i,
  output logic [Width-1:0] rdata_o
);

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);

  logic [Width-1:0] mem_q [Depth];
  logic [PtrW-1:0]  wptr_q;
  logic [PtrW-1:0]  rptr_q;
  logic [CntW-1:0]  count_q;
  logic             push;
  logic             pop;

  // Full and empty come from the fill count
  assign wready_o = (count_q != CntW'(Depth));
  assign rvalid_o = (count_q != '0);
  assign push     = wvalid_i && wready_o;
  assign pop      = rready_i && rvalid_o;

  // Head entry, visible the cycle after its push
  assign rdata_o = mem_q[rptr_q];

  // Storage array
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      // Pointers wrap at Depth, which need not be a power of two
      if (push) begin
        wptr_q <= (wptr_q == PtrW'(Depth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == PtrW'(Depth - 1)) ? '0 : rptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Producers in the adapter only write with room left
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wvalid_i |-> wready_o);

  // Consumers only pop a valid head
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rready_i |-> rvalid_o);

endmodule

`default_nettype wire

/* tluh_req_check.sv */
`default_nettype none

`include "tluh_sram_macros.svh"

module tluh_req_check import tluh_sram_pkg::*; #(
  parameter bit ByteAccess = 1'b1
) (
  input  logic [`TLUH_OPW-1:0] a_opcode_i,
  input  atomic_param_u        a_param_i,
  input  logic [`TLUH_SZW-1:0] a_size_i,
  input  logic [`TLUH_AW-1:0]  a_address_i,
  input  logic [`TLUH_DBW-1:0] a_mask_i,
  output logic                 err_o
);

  logic [`TLUH_DBW-1:0] exp_mask;
  logic                 op_err;
  logic                 size_err;
  logic                 align_err;
  logic                 mask_err;
  logic                 fn_err;
  logic                 partial_err;

  // Lanes covered by size and address
  always_comb begin
    case (a_size_i)
      2'd0:    exp_mask = `TLUH_DBW'(1) << a_address_i[1:0];
      2'd1:    exp_mask = `TLUH_DBW'(3) << {a_address_i[1], 1'b0};
      default: exp_mask = {`TLUH_DBW{1'b1}};
    endcase
  end

  // Intent and anything unlisted
  assign op_err = !(a_opcode_i inside {`TLUH_PUT_FULL, `TLUH_PUT_PARTIAL, `TLUH_ARITH,
                                       `TLUH_LOGIC, `TLUH_GET});
  // No bursts, one word at most
  assign size_err  = (a_size_i > 2'd2);
  assign align_err = ((a_size_i == 2'd1) && a_address_i[0]) ||
                     ((a_size_i == 2'd2) && (a_address_i[1:0] != 2'b00));
  // PutPartial may carry any subset of lanes
  assign mask_err  = (a_opcode_i != `TLUH_PUT_PARTIAL) && (a_mask_i != exp_mask);
  assign fn_err    = ((a_opcode_i == `TLUH_ARITH) && (a_param_i.arith_fn > `TLUH_ARITH_ADD)) ||
                     ((a_opcode_i == `TLUH_LOGIC) && (a_param_i.logic_fn > `TLUH_LOGIC_SWAP));
  assign partial_err = !ByteAccess && (a_opcode_i == `TLUH_PUT_PARTIAL);

  assign err_o = op_err | size_err | align_err | mask_err | fn_err | partial_err;

endmodule

`default_nettype wire

/* tluh_req_issue.sv */
`default_nettype none

`include "tluh_sram_macros.svh"

module tluh_req_issue import tluh_sram_pkg::*; (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // A channel
  input  logic                             a_valid_i,
  input  logic [`TLUH_OPW-1:0]             a_opcode_i,
  input  atomic_param_u                    a_param_i,
  input  logic [`TLUH_SZW-1:0]             a_size_i,
  input  logic [`TLUH_AIW-1:0]             a_source_i,
  input  logic [`TLUH_AW-1:0]              a_address_i,
  input  logic [`TLUH_DBW-1:0]             a_mask_i,
  input  logic [`TLUH_DW-1:0]              a_data_i,
  output logic                             a_ready_o,
  input  logic                             err_i,
  // Request queue push
  output logic                             req_fifo_wvalid_o,
  input  logic                             req_fifo_wready_i,
  output logic [`TLUH_AIW+`TLUH_SZW+1:0]   req_fifo_wdata_o,
  // SRAM port
  output logic                             req_o,
  output logic                             we_o,
  output logic [`TLUH_SRAM_AW-1:0]         addr_o,
  output logic [`TLUH_DW-1:0]              wdata_o,
  output logic [`TLUH_DW-1:0]              wmask_o,
  input  logic                             gnt_i,
  input  logic                             rvalid_i,
  input  logic [`TLUH_DW-1:0]              rdata_i,
  // Atomic ALU
  output logic                             alu_arith_o,
  output atomic_param_u                    alu_func_o,
  output logic [`TLUH_DW-1:0]              alu_old_o,
  output logic [`TLUH_DW-1:0]              alu_operand_o,
  output logic [`TLUH_DBW-1:0]             alu_mask_o,
  input  logic [`TLUH_DW-1:0]              alu_result_i
);

  typedef enum logic {
    IDLE,
    WRITE_BACK
  } state_e;

  state_e                   state_q;
  logic                     old_valid_q;
  logic [`TLUH_SRAM_AW-1:0] addr_q;
  logic [`TLUH_DW-1:0]      operand_q;
  logic [`TLUH_DW-1:0]      old_q;
  logic [`TLUH_DBW-1:0]     mask_q;
  atomic_param_u            func_q;
  logic                     arith_q;

  logic                     is_write;
  logic                     is_atomic;
  logic                     is_read;
  logic                     a_ack;
  logic                     atomic_start;
  logic                     take_old;
  logic [`TLUH_DW-1:0]      a_bitmask;
  logic [`TLUH_DW-1:0]      wb_bitmask;

  assign is_write  = a_opcode_i inside {`TLUH_PUT_FULL, `TLUH_PUT_PARTIAL};
  assign is_atomic = a_opcode_i inside {`TLUH_ARITH, `TLUH_LOGIC};
  // Atomics answer with data like a Get
  assign is_read   = is_atomic || (a_opcode_i == `TLUH_GET);

  // Erroneous beats skip the SRAM, so they need no grant
  assign a_ready_o    = (state_q == IDLE) && req_fifo_wready_i && (gnt_i || err_i);
  assign a_ack        = a_valid_i && a_ready_o;
  assign atomic_start = a_ack && is_atomic && !err_i;
  // First cycle after the atomic read grant carries the old word
  assign take_old     = (state_q == WRITE_BACK) && rvalid_i && !old_valid_q;

  // Entry layout is is_read, error, size, source
  assign req_fifo_wvalid_o = a_ack;
  assign req_fifo_wdata_o  = {is_read, err_i, a_size_i, a_source_i};

  // Byte enables widened to bit enables
  always_comb begin
    for (int i = 0; i < `TLUH_DBW; i++) begin
      a_bitmask[8*i +: 8]  = {8{a_mask_i[i]}};
      wb_bitmask[8*i +: 8] = {8{mask_q[i]}};
    end
  end

  // SRAM port, A beat in IDLE and merged write in WRITE_BACK
  always_comb begin
    if (state_q == WRITE_BACK) begin
      req_o   = old_valid_q;
      we_o    = 1'b1;
      addr_o  = addr_q;
      wdata_o = alu_result_i;
      wmask_o = wb_bitmask;
    end else begin
      // Queue room is required so that a grant always means acceptance
      req_o   = a_valid_i && !err_i && req_fifo_wready_i;
      we_o    = is_write;
      addr_o  = a_address_i[`TLUH_SRAM_AW+1:2];
      wdata_o = a_data_i & a_bitmask;
      wmask_o = a_bitmask;
    end
  end

  // Atomic sequencer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      old_valid_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (atomic_start) begin
            state_q     <= WRITE_BACK;
            old_valid_q <= 1'b0;
          end
        end
        WRITE_BACK: begin
          if (take_old) begin
            old_valid_q <= 1'b1;
          end
          // Stay until the merged write is taken
          if (req_o && gnt_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Operands of the pending atomic
  always_ff @(posedge clk_i) begin
    if (atomic_start) begin
      addr_q    <= a_address_i[`TLUH_SRAM_AW+1:2];
      operand_q <= a_data_i;
      mask_q    <= a_mask_i;
      func_q    <= a_param_i;
      arith_q   <= (a_opcode_i == `TLUH_ARITH);
    end
    if (take_old) begin
      old_q <= rdata_i;
    end
  end

  assign alu_arith_o   = arith_q;
  assign alu_func_o    = func_q;
  assign alu_old_o     = old_q;
  assign alu_operand_o = operand_q;
  assign alu_mask_o    = mask_q;

  // The SRAM returns the atomic read exactly one cycle after its grant
  a_atomic_read_return: assert property (@(posedge clk_i) disable iff (!rst_ni)
    atomic_start |=> rvalid_i);

  // In WRITE_BACK req_o only rises for the write, right after the old word
  a_wb_req_is_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == WRITE_BACK) && $rose(req_o) |-> we_o && $past(rvalid_i));

endmodule

`default_nettype wire

/* tluh_rsp_gen.sv */
`default_nettype none

`include "tluh_sram_macros.svh"

module tluh_rsp_gen (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // SRAM read return
  input  logic                           rvalid_i,
  input  logic [`TLUH_DW-1:0]            rdata_i,
  input  logic                           rerror_i,
  // Request queue head
  input  logic                           req_fifo_rvalid_i,
  input  logic [`TLUH_AIW+`TLUH_SZW+1:0] req_fifo_rdata_i,
  output logic                           req_fifo_rready_o,
  // Response queue
  output logic                           rsp_fifo_wvalid_o,
  output logic [`TLUH_DW:0]              rsp_fifo_wdata_o,
  input  logic                           rsp_fifo_rvalid_i,
  input  logic [`TLUH_DW:0]              rsp_fifo_rdata_i,
  output logic                           rsp_fifo_rready_o,
  // D channel
  output logic                           d_valid_o,
  output logic [`TLUH_OPW-1:0]           d_opcode_o,
  output logic [`TLUH_SZW-1:0]           d_size_o,
  output logic [`TLUH_AIW-1:0]           d_source_o,
  output logic [`TLUH_DW-1:0]            d_data_o,
  output logic                           d_error_o,
  input  logic                           d_ready_i
);

  logic                 head_read;
  logic                 head_err;
  logic [`TLUH_SZW-1:0] head_size;
  logic [`TLUH_AIW-1:0] head_source;
  logic                 needs_data;
  logic                 d_ack;

  // Entry layout is is_read, error, size, source
  assign {head_read, head_err, head_size, head_source} = req_fifo_rdata_i;

  // Only reads that went to the SRAM own a response entry
  assign needs_data = head_read && !head_err;

  // Every SRAM return is queued with its uncorrectable flag
  assign rsp_fifo_wvalid_o = rvalid_i;
  assign rsp_fifo_wdata_o  = {rerror_i, rdata_i};

  // Errors and writes go out as soon as they reach the head
  assign d_valid_o = req_fifo_rvalid_i && (!needs_data || rsp_fifo_rvalid_i);
  assign d_ack     = d_valid_o && d_ready_i;

  assign d_opcode_o = head_read ? `TLUH_ACCESS_ACK_DATA : `TLUH_ACCESS_ACK;
  assign d_size_o   = head_size;
  assign d_source_o = head_source;
  // Error reads return zero data
  assign d_data_o   = needs_data ? rsp_fifo_rdata_i[`TLUH_DW-1:0] : '0;
  assign d_error_o  = head_err || (needs_data && rsp_fifo_rdata_i[`TLUH_DW]);

  // Pop both queues together on a D transfer
  assign req_fifo_rready_o = d_ack;
  assign rsp_fifo_rready_o = d_ack && needs_data;

  // A stalled response holds all its fields until taken
  a_d_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    d_valid_o && !d_ready_i |=> d_valid_o &&
      $stable({d_opcode_o, d_size_o, d_source_o, d_data_o, d_error_o}));

endmodule

`default_nettype wire

/* tluh_sram_adapter.f */
+incdir+.
tluh_sram_pkg.sv
tluh_fifo_sync.sv
tluh_req_check.sv
tluh_atomic_alu.sv
tluh_req_issue.sv
tluh_rsp_gen.sv
tluh_sram_adapter.sv
tb_sram_model.sv
tb_tluh_sram_adapter.sv

/* tluh_sram_adapter.sv */
`default_nettype none

`include "tluh_sram_macros.svh"

module tluh_sram_adapter import tluh_sram_pkg::*; #(
  parameter bit ByteAccess = 1'b1
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // TL-UH A channel
  input  logic                     a_valid_i,
  input  logic [`TLUH_OPW-1:0]     a_opcode_i,
  input  atomic_param_u            a_param_i,
  input  logic [`TLUH_SZW-1:0]     a_size_i,
  input  logic [`TLUH_AIW-1:0]     a_source_i,
  input  logic [`TLUH_AW-1:0]      a_address_i,
  input  logic [`TLUH_DBW-1:0]     a_mask_i,
  input  logic [`TLUH_DW-1:0]      a_data_i,
  output logic                     a_ready_o,
  // TL-UH D channel
  output logic                     d_valid_o,
  output logic [`TLUH_OPW-1:0]     d_opcode_o,
  output logic [`TLUH_SZW-1:0]     d_size_o,
  output logic [`TLUH_AIW-1:0]     d_source_o,
  output logic [`TLUH_DW-1:0]      d_data_o,
  output logic                     d_error_o,
  input  logic                     d_ready_i,
  // SRAM
  output logic                     req_o,
  output logic                     we_o,
  output logic [`TLUH_SRAM_AW-1:0] addr_o,
  output logic [`TLUH_DW-1:0]      wdata_o,
  output logic [`TLUH_DW-1:0]      wmask_o,
  input  logic                     gnt_i,
  input  logic                     rvalid_i,
  input  logic [`TLUH_DW-1:0]      rdata_i,
  input  logic                     rerror_i
);

  // is_read, error, size, source
  localparam int ReqW = `TLUH_AIW + `TLUH_SZW + 2;
  // Uncorrectable flag on top of the data word
  localparam int RspW = `TLUH_DW + 1;

  logic                 req_err;
  logic                 req_fifo_wvalid;
  logic                 req_fifo_wready;
  logic [ReqW-1:0]      req_fifo_wdata;
  logic                 req_fifo_rvalid;
  logic                 req_fifo_rready;
  logic [ReqW-1:0]      req_fifo_rdata;
  logic                 rsp_fifo_wvalid;
  logic [RspW-1:0]      rsp_fifo_wdata;
  logic                 rsp_fifo_rvalid;
  logic                 rsp_fifo_rready;
  logic [RspW-1:0]      rsp_fifo_rdata;
  logic                 alu_arith;
  atomic_param_u        alu_func;
  logic [`TLUH_DW-1:0]  alu_old;
  logic [`TLUH_DW-1:0]  alu_operand;
  logic [`TLUH_DBW-1:0] alu_mask;
  logic [`TLUH_DW-1:0]  alu_result;

  tluh_req_check #(
    .ByteAccess (ByteAccess)
  ) u_req_check (
    .a_opcode_i  (a_opcode_i),
    .a_param_i   (a_param_i),
    .a_size_i    (a_size_i),
    .a_address_i (a_address_i),
    .a_mask_i    (a_mask_i),
    .err_o       (req_err)
  );

  tluh_req_issue u_req_issue (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .a_valid_i         (a_valid_i),
    .a_opcode_i        (a_opcode_i),
    .a_param_i         (a_param_i),
    .a_size_i          (a_size_i),
    .a_source_i        (a_source_i),
    .a_address_i       (a_address_i),
    .a_mask_i          (a_mask_i),
    .a_data_i          (a_data_i),
    .a_ready_o         (a_ready_o),
    .err_i             (req_err),
    .req_fifo_wvalid_o (req_fifo_wvalid),
    .req_fifo_wready_i (req_fifo_wready),
    .req_fifo_wdata_o  (req_fifo_wdata),
    .req_o             (req_o),
    .we_o              (we_o),
    .addr_o            (addr_o),
    .wdata_o           (wdata_o),
    .wmask_o           (wmask_o),
    .gnt_i             (gnt_i),
    .rvalid_i          (rvalid_i),
    .rdata_i           (rdata_i),
    .alu_arith_o       (alu_arith),
    .alu_func_o        (alu_func),
    .alu_old_o         (alu_old),
    .alu_operand_o     (alu_operand),
    .alu_mask_o        (alu_mask),
    .alu_result_i      (alu_result)
  );

  tluh_atomic_alu u_atomic_alu (
    .is_arith_i (alu_arith),
    .func_i     (alu_func),
    .old_i      (alu_old),
    .operand_i  (alu_operand),
    .mask_i     (alu_mask),
    .result_o   (alu_result)
  );

  // Requests in flight in A order
  tluh_fifo_sync #(
    .Width (ReqW),
    .Depth (`TLUH_OUTSTANDING)
  ) u_req_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (req_fifo_wvalid),
    .wready_o (req_fifo_wready),
    .wdata_i  (req_fifo_wdata),
    .rvalid_o (req_fifo_rvalid),
    .rready_i (req_fifo_rready),
    .rdata_o  (req_fifo_rdata)
  );

  // Read data held while the host stalls D
  // Never full on a push because every read first took a request entry
  tluh_fifo_sync #(
    .Width (RspW),
    .Depth (`TLUH_OUTSTANDING)
  ) u_rsp_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (rsp_fifo_wvalid),
    .wready_o (),
    .wdata_i  (rsp_fifo_wdata),
    .rvalid_o (rsp_fifo_rvalid),
    .rready_i (rsp_fifo_rready),
    .rdata_o  (rsp_fifo_rdata)
  );

  tluh_rsp_gen u_rsp_gen (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .rvalid_i          (rvalid_i),
    .rdata_i           (rdata_i),
    .rerror_i          (rerror_i),
    .req_fifo_rvalid_i (req_fifo_rvalid),
    .req_fifo_rdata_i  (req_fifo_rdata),
    .req_fifo_rready_o (req_fifo_rready),
    .rsp_fifo_wvalid_o (rsp_fifo_wvalid),
    .rsp_fifo_wdata_o  (rsp_fifo_wdata),
    .rsp_fifo_rvalid_i (rsp_fifo_rvalid),
    .rsp_fifo_rdata_i  (rsp_fifo_rdata),
    .rsp_fifo_rready_o (rsp_fifo_rready),
    .d_valid_o         (d_valid_o),
    .d_opcode_o        (d_opcode_o),
    .d_size_o          (d_size_o),
    .d_source_o        (d_source_o),
    .d_data_o          (d_data_o),
    .d_error_o         (d_error_o),
    .d_ready_i         (d_ready_i)
  );

endmodule

`default_nettype wire

/* tluh_sram_macros.svh */
`ifndef TLUH_SRAM_MACROS_SVH
`define TLUH_SRAM_MACROS_SVH

// Bus and memory geometry
`define TLUH_DW          32
`define TLUH_DBW         4
`define TLUH_AW          32
`define TLUH_SZW         2
`define TLUH_AIW         8
`define TLUH_OPW         3
`define TLUH_SRAM_AW     10
// Entries in both the request and response queue
`define TLUH_OUTSTANDING 2

// A channel opcodes
`define TLUH_PUT_FULL    3'd0
`define TLUH_PUT_PARTIAL 3'd1
`define TLUH_ARITH       3'd2
`define TLUH_LOGIC       3'd3
`define TLUH_GET         3'd4
`define TLUH_INTENT      3'd5

// D channel opcodes
`define TLUH_ACCESS_ACK      3'd0
`define TLUH_ACCESS_ACK_DATA 3'd1

// Functions of ArithmeticData
`define TLUH_ARITH_MIN  3'd0
`define TLUH_ARITH_MAX  3'd1
`define TLUH_ARITH_MINU 3'd2
`define TLUH_ARITH_MAXU 3'd3
`define TLUH_ARITH_ADD  3'd4

// Functions of LogicalData
`define TLUH_LOGIC_XOR  3'd0
`define TLUH_LOGIC_OR   3'd1
`define TLUH_LOGIC_AND  3'd2
`define TLUH_LOGIC_SWAP 3'd3

`endif

/* tluh_sram_pkg.sv */
`default_nettype none

package tluh_sram_pkg;

  // The a_param field of an atomic request
  // Same three bits, decoded per opcode
  typedef union packed {
    // Function code under ArithmeticData
    logic [2:0] arith_fn;
    // Function code under LogicalData
    logic [2:0] logic_fn;
  } atomic_param_u;

endpackage

`default_nettype wire
